//--- flist.f
rtl/usb_rx_pkg.sv
rtl/usb_line_recovery.sv
rtl/usb_bit_decoder.sv
rtl/usb_crc_check.sv
rtl/usb_packet_decoder.sv
rtl/usb_fs_rx_top.sv
+incdir+test
test/tb_usb_fs_rx.sv

//--- rtl/usb_bit_decoder.sv
// second receive stage, frames packets on sync and EOP in the symbol history
// then undoes NRZI and bit stuffing to give one strobe per payload bit
`timescale 1ns/10ps

module usb_bit_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  usb_rx_pkg::line_sample_t sample_i,
  output usb_rx_pkg::rx_bit_t      bit_o
);

  logic [11:0] hist_q;
  logic        hist_upd_q;
  logic        pkt_valid_q, pkt_valid_d;
  logic [6:0]  run_q;
  logic        stuff_err_q;
  logic        see_sync, see_eop, pair_ok;
  logic        raw_valid, raw_bit;
  logic        pkt_start, pkt_end;

  // hist_upd_q marks the cycle in which the history holds a fresh symbol
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q     <= usb_rx_pkg::HIST_RESET;
      hist_upd_q <= 1'b0;
    end else begin
      hist_upd_q <= sample_i.strobe;
      if (sample_i.strobe) begin
        hist_q <= {hist_q[9:0], sample_i.symbol};
      end
    end
  end

  //////////////////////
  // packet framing
  //////////////////////

  assign see_sync = (hist_q == usb_rx_pkg::SYNC_PATTERN);
  // end of packet is two SE0 bit times, or an early stop on a stuffing error
  assign see_eop  = (hist_q[3:0] == 4'b0000) || stuff_err_q;

  always_comb begin
    pkt_valid_d = pkt_valid_q;
    if (hist_upd_q) begin
      if (!pkt_valid_q && see_sync) begin
        pkt_valid_d = 1'b1;
      end else if (pkt_valid_q && see_eop) begin
        pkt_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_valid_q <= 1'b0;
    end else begin
      pkt_valid_q <= pkt_valid_d;
    end
  end

  assign pkt_start = pkt_valid_d & ~pkt_valid_q;
  assign pkt_end   = ~pkt_valid_d & pkt_valid_q;

  //////////////////////
  // NRZI and unstuff
  //////////////////////

  // J and K differ on both wires, so an odd pair is a data symbol
  assign pair_ok   = (^hist_q[3:2]) && (^hist_q[1:0]);
  assign raw_valid = hist_upd_q && pkt_valid_q && !see_eop && pair_ok;
  // no change between symbols is a one, a change is a zero
  assign raw_bit   = (hist_q[3:2] == hist_q[1:0]);

  // every raw bit enters the run history, stuffed zeros included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q       <= 7'd0;
      stuff_err_q <= 1'b0;
    end else if (pkt_start) begin
      run_q       <= 7'd0;
      stuff_err_q <= 1'b0;
    end else begin
      if (raw_valid) begin
        run_q <= {run_q[5:0], raw_bit};
      end
      // seven ones in a row are illegal anywhere in the packet
      if (&run_q) begin
        stuff_err_q <= 1'b1;
      end
    end
  end

  // the bit after six ones is the stuffed one and is dropped
  assign bit_o.bit_valid = raw_valid && (run_q[5:0] != 6'h3f);
  assign bit_o.bit_value = raw_bit;
  assign bit_o.pkt_start = pkt_start;
  assign bit_o.pkt_end   = pkt_end;
  assign bit_o.stuff_err = pkt_end && stuff_err_q;

  // one bit per four clocks at most, so the packet decoder never sees two bits close together
  a_bit_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bit_o.bit_valid |-> !$past(bit_o.bit_valid) && !$past(bit_o.bit_valid, 2) &&
                        !$past(bit_o.bit_valid, 3));

endmodule

//--- rtl/usb_crc_check.sv
// serial CRC5 and CRC16 over the payload bits that follow the PID
// both registers run on every bit, the packet decoder picks the one it needs
`timescale 1ns/10ps

module usb_crc_check (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic bit_valid_i,
  input  logic bit_i,
  output logic crc5_ok_o,
  output logic crc16_ok_o
);

  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic        crc5_fb, crc16_fb;

  // feedback is the incoming bit against the top of each register
  assign crc5_fb  = bit_i ^ crc5_q[4];
  assign crc16_fb = bit_i ^ crc16_q[15];

  // both registers preset to all ones at the start of every packet
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc5_q  <= '1;
      crc16_q <= '1;
    end else if (start_i) begin
      crc5_q  <= '1;
      crc16_q <= '1;
    end else if (bit_valid_i) begin
      crc5_q  <= {crc5_q[3:0], 1'b0} ^ ({5{crc5_fb}} & usb_rx_pkg::CRC5_POLY);
      crc16_q <= {crc16_q[14:0], 1'b0} ^ ({16{crc16_fb}} & usb_rx_pkg::CRC16_POLY);
    end
  end

  // running the received CRC through the register leaves a fixed residue
  assign crc5_ok_o  = (crc5_q == usb_rx_pkg::CRC5_RESIDUE);
  assign crc16_ok_o = (crc16_q == usb_rx_pkg::CRC16_RESIDUE);

endmodule

//--- rtl/usb_fs_rx_top.sv
// full-speed USB receiver top, dp/dn in at four clk_i cycles per bit
// chains line recovery, bit decoding and packet decoding
`timescale 1ns/10ps

module usb_fs_rx_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      usb_dp_i,
  input  logic                      usb_dn_i,
  output logic                      pkt_start_o,
  output logic                      pkt_end_o,
  output logic                      rx_data_put_o,
  output logic [7:0]                rx_data_o,
  output usb_rx_pkg::token_fields_t token_o,
  output usb_rx_pkg::rx_status_t    status_o
);

  usb_rx_pkg::line_sample_t line_sample;
  usb_rx_pkg::rx_bit_t      rx_bit;

  // stage 1 recovers line state and the mid-bit strobe
  usb_line_recovery usb_line_recovery_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .usb_dp_i (usb_dp_i),
    .usb_dn_i (usb_dn_i),
    .sample_o (line_sample)
  );

  // stage 2 frames packets and recovers the unstuffed bits
  usb_bit_decoder usb_bit_decoder_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .sample_i (line_sample),
    .bit_o    (rx_bit)
  );

  // stage 3 checks the packet and delivers bytes and fields
  usb_packet_decoder usb_packet_decoder_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bit_i      (rx_bit),
    .data_put_o (rx_data_put_o),
    .data_o     (rx_data_o),
    .token_o    (token_o),
    .status_o   (status_o)
  );

  assign pkt_start_o = rx_bit.pkt_start;
  assign pkt_end_o   = rx_bit.pkt_end;

endmodule

//--- rtl/usb_line_recovery.sv
// first receive stage, turns the oversampled dp/dn pair into one symbol per bit
// the strobe marks the mid-bit sample that the bit decoder consumes
`timescale 1ns/10ps

module usb_line_recovery (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     usb_dp_i,
  input  logic                     usb_dn_i,
  output usb_rx_pkg::line_sample_t sample_o
);

  usb_rx_pkg::line_state_e state_q, state_d;
  logic [1:0]              dpair;
  logic [1:0]              phase_q;

  assign dpair = {usb_dp_i, usb_dn_i};

  ////////////////////
  // line state FSM
  ////////////////////

  // a change on the pair first parks the FSM in the transition state
  // the pair is taken one cycle later, once both wires have settled
  // so skew between dp and dn never shows up as a short SE0
  always_comb begin
    state_d = state_q;
    if (state_q == usb_rx_pkg::LS_DT) begin
      state_d = usb_rx_pkg::line_state_e'({1'b0, dpair});
    end else if (dpair != state_q[1:0]) begin
      state_d = usb_rx_pkg::LS_DT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= usb_rx_pkg::LS_SE0;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // clock recovery
  ////////////////////

  // every line edge realigns the phase so the sample lands mid-bit
  // with four clocks per bit the counter simply wraps between edges
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 2'd0;
    end else if (state_q == usb_rx_pkg::LS_DT) begin
      phase_q <= 2'd0;
    end else begin
      phase_q <= phase_q + 2'd1;
    end
  end

  // never sample during a transition, the symbol is only J, K or SE0
  assign sample_o.strobe = (phase_q == usb_rx_pkg::SAMPLE_PHASE) &&
                           (state_q != usb_rx_pkg::LS_DT);
  assign sample_o.symbol = state_q[1:0];

  // a clean line settles within one clock, so a pair still moving in the transition state is noise
  a_dt_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == usb_rx_pkg::LS_DT |-> dpair == $past(dpair));

endmodule

//--- rtl/usb_packet_decoder.sv
// third receive stage, checks the PID, counts length and runs the CRCs
// it assembles data bytes and token fields and reports status at pkt_end
`timescale 1ns/10ps

module usb_packet_decoder (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  usb_rx_pkg::rx_bit_t       bit_i,
  output logic                      data_put_o,
  output logic [7:0]                data_o,
  output usb_rx_pkg::token_fields_t token_o,
  output usb_rx_pkg::rx_status_t    status_o
);

  logic [8:0]  pid_q;
  logic        pid_done, pid_ok;
  logic [1:0]  pid_type;
  logic        is_token, is_data, is_hs;
  logic        pay_valid;
  logic [3:0]  len_q;
  logic        len16_q, over16_q;
  logic        len_tok_ok, len_data_ok, len_hs_ok;
  logic [10:0] tok_q;
  logic [8:0]  byte_q;
  logic        stuff_seen_q, stuff_any;
  logic        crc5_ok, crc16_ok;

  // the PID shifts in LSB first behind a sentinel that marks eight bits
  assign pid_done  = pid_q[0];
  assign pid_ok    = (pid_q[4:1] == ~pid_q[8:5]);
  assign pid_type  = pid_q[2:1];
  assign is_token  = (pid_type == usb_rx_pkg::PID_TYPE_TOKEN);
  assign is_data   = (pid_type == usb_rx_pkg::PID_TYPE_DATA);
  assign is_hs     = (pid_type == usb_rx_pkg::PID_TYPE_HANDSHAKE);
  assign pay_valid = bit_i.bit_valid && pid_done;

  // tokens are exactly 16 bits, data is byte aligned with at least the CRC16
  assign len_tok_ok  = len16_q && !over16_q;
  assign len_data_ok = len16_q && (len_q[2:0] == 3'd0);
  assign len_hs_ok   = !len16_q && (len_q == 4'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q        <= 9'd0;
      len_q        <= 4'd0;
      len16_q      <= 1'b0;
      over16_q     <= 1'b0;
      tok_q        <= 11'd0;
      byte_q       <= 9'd0;
      stuff_seen_q <= 1'b0;
    end else if (bit_i.pkt_start) begin
      pid_q        <= 9'h100;
      len_q        <= 4'd0;
      len16_q      <= 1'b0;
      over16_q     <= 1'b0;
      tok_q        <= 11'd0;
      byte_q       <= 9'h100;
      stuff_seen_q <= 1'b0;
    end else begin
      if (bit_i.bit_valid && !pid_done) begin
        pid_q <= {bit_i.bit_value, pid_q[8:1]};
      end
      if (pay_valid) begin
        len_q    <= len_q + 4'd1;
        len16_q  <= len16_q | (&len_q);
        over16_q <= over16_q | len16_q;
      end
      // only the first 11 token bits are fields, the CRC5 follows them
      if (pay_valid && is_token && !len16_q && (len_q < 4'd11)) begin
        tok_q <= {bit_i.bit_value, tok_q[10:1]};
      end
      // a full byte is shown for one cycle and the shifter rearms behind it
      if (byte_q[0]) begin
        byte_q <= 9'h100;
      end else if (pay_valid && is_data) begin
        byte_q <= {bit_i.bit_value, byte_q[8:1]};
      end
      if (bit_i.stuff_err) begin
        stuff_seen_q <= 1'b1;
      end
    end
  end

  usb_crc_check usb_crc_check_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (bit_i.pkt_start),
    .bit_valid_i (pay_valid),
    .bit_i       (bit_i.bit_value),
    .crc5_ok_o   (crc5_ok),
    .crc16_ok_o  (crc16_ok)
  );

  assign data_put_o = byte_q[0];
  assign data_o     = byte_q[8:1];
  assign token_o    = usb_rx_pkg::token_fields_t'(tok_q);

  // the stuffing flag arrives on pkt_end itself and is held after it
  assign stuff_any = stuff_seen_q || bit_i.stuff_err;

  assign status_o.pid       = usb_rx_pkg::pid_e'(pid_q[4:1]);
  assign status_o.pid_ok    = pid_ok;
  assign status_o.packet_ok = pid_ok && !stuff_any &&
                              ((is_hs && len_hs_ok) ||
                               (is_data && len_data_ok && crc16_ok) ||
                               (is_token && len_tok_ok && crc5_ok));
  assign status_o.crc5_err  = bit_i.pkt_end && is_token && !crc5_ok;
  assign status_o.crc16_err = bit_i.pkt_end && is_data && !crc16_ok;
  assign status_o.pid_err   = bit_i.pkt_end && !pid_ok;
  assign status_o.stuff_err = bit_i.stuff_err;

  // the rearm cycle of the byte shifter takes no bit, so a bit arriving then would be lost
  a_no_bit_lost: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_put_o |-> !bit_i.bit_valid);

endmodule

//--- rtl/usb_rx_pkg.sv
// shared types and constants for the full-speed USB packet receiver
// every RTL file refers to these by scoped name

package usb_rx_pkg;

  // line states with J and K taken straight from the {dp, dn} pair
  typedef enum logic [2:0] {
    LS_SE0 = 3'b000,
    LS_K   = 3'b001,
    LS_J   = 3'b010,
    LS_DT  = 3'b100
  } line_state_e;

  // phase count at which a settled symbol is taken, two cycles past a realign
  localparam logic [1:0] SAMPLE_PHASE = 2'd1;

  // symbol history holds six 2-bit symbols with the newest in the low bits
  localparam logic [11:0] HIST_RESET   = 12'b01_01_01_01_01_01;
  localparam logic [11:0] SYNC_PATTERN = 12'b01_10_01_10_01_01;

  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } pid_e;

  // the two low PID bits give the packet class
  localparam logic [1:0] PID_TYPE_TOKEN     = 2'b01;
  localparam logic [1:0] PID_TYPE_DATA      = 2'b11;
  localparam logic [1:0] PID_TYPE_HANDSHAKE = 2'b10;

  localparam logic [4:0]  CRC5_POLY     = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b01100;
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

  typedef struct packed {
    logic       strobe;
    logic [1:0] symbol;
  } line_sample_t;

  typedef struct packed {
    logic bit_valid;
    logic bit_value;
    logic pkt_start;
    logic pkt_end;
    logic stuff_err;
  } rx_bit_t;

  // the 11 token bits are either address and endpoint or a frame number
  typedef union packed {
    struct packed {
      logic [3:0] endp;
      logic [6:0] addr;
    } fields;
    logic [10:0] frame;
  } token_fields_t;

  typedef struct packed {
    pid_e pid;
    logic pid_ok;
    logic packet_ok;
    logic crc5_err;
    logic crc16_err;
    logic pid_err;
    logic stuff_err;
  } rx_status_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build the receiver testbench with Verilator and run it
# the run passes only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_usb_fs_rx -Mdir obj_dir \
  && ./obj_dir/Vtb_usb_fs_rx | tee /dev/stderr | grep -q "^TB PASSED$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- test/usb_line_driver.svh
// packet encoder for the receiver testbench, included inside the testbench module
// holds the reference CRCs and the tasks that stuff, NRZI code and drive dp/dn
`ifndef USB_LINE_DRIVER_SVH
`define USB_LINE_DRIVER_SVH

// USB CRC5 over the 11 token bits taken LSB first, returned already inverted
function automatic logic [4:0] crc5_ref(input logic [10:0] data);
  logic [4:0] crc;
  logic       fb;
  crc = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    fb  = data[i] ^ crc[4];
    crc = {crc[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
  end
  return ~crc;
endfunction

// USB CRC16 over the data bits in wire order, returned already inverted
function automatic logic [15:0] crc16_ref(input logic bits[$]);
  logic [15:0] crc;
  logic        fb;
  crc = 16'hffff;
  foreach (bits[i]) begin
    fb  = bits[i] ^ crc[15];
    crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
  end
  return ~crc;
endfunction

// one bit time is four clocks, the pair changes just after a falling edge
task automatic drive_symbol(input logic dp, input logic dn);
  usb_dp = dp;
  usb_dn = dn;
  repeat (4) @(negedge clk);
endtask

// level is 1 for J; a zero toggles the line and a one holds it
// after six ones a zero is stuffed unless stuffing is switched off
task automatic send_line(input logic bits[$], input logic stuff_en);
  logic level;
  int   ones;
  level = 1'b1;
  ones  = 0;
  foreach (bits[i]) begin
    if (bits[i]) begin
      ones++;
    end else begin
      level = ~level;
      ones  = 0;
    end
    drive_symbol(level, ~level);
    if (stuff_en && ones == 6) begin
      level = ~level;
      ones  = 0;
      drive_symbol(level, ~level);
    end
  end
  // EOP is two SE0 bit times and then J
  drive_symbol(1'b0, 1'b0);
  drive_symbol(1'b0, 1'b0);
  drive_symbol(1'b1, 1'b0);
endtask

`endif

//--- test/tb_usb_fs_rx.sv
// testbench for the full-speed USB receiver
// sends one packet per table row and checks bytes, token and status at pkt_end
`timescale 1ns/10ps

module tb_usb_fs_rx;

  localparam int NUM_ROWS       = 13;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 400;
  localparam int CORR_NONE      = 0;
  localparam int CORR_CRC       = 1;
  localparam int CORR_PID       = 2;
  localparam int CORR_STUFF     = 3;

  typedef struct {
    usb_rx_pkg::pid_e          pid;
    int                        nbytes;
    usb_rx_pkg::token_fields_t tok;
    int                        corrupt;
    usb_rx_pkg::rx_status_t    exp_status;
    int                        exp_count;
  } row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      usb_dp;
  logic                      usb_dn;
  logic                      pkt_start;
  logic                      pkt_end;
  logic                      data_put;
  logic [7:0]                data;
  usb_rx_pkg::token_fields_t token;
  usb_rx_pkg::rx_status_t    status;

  row_t        table_q[NUM_ROWS];
  logic [7:0]  exp_bytes[$];
  logic [31:0] rng_state   = 32'd33;
  int          n_rows      = 0;
  int          cur_row     = 0;
  int          bytes_got   = 0;
  int          starts_seen = 0;
  int          ends_seen   = 0;
  int          checks      = 0;
  int          errors      = 0;
  int          cycles      = 0;

  `include "usb_line_driver.svh"

  usb_fs_rx_top usb_fs_rx_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .usb_dp_i      (usb_dp),
    .usb_dn_i      (usb_dn),
    .pkt_start_o   (pkt_start),
    .pkt_end_o     (pkt_end),
    .rx_data_put_o (data_put),
    .rx_data_o     (data),
    .token_o       (token),
    .status_o      (status)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // flags are pid_ok, packet_ok, crc5_err, crc16_err, pid_err, stuff_err
  function automatic usb_rx_pkg::rx_status_t make_status(input usb_rx_pkg::pid_e pid,
                                                         input logic [5:0] flags);
    return usb_rx_pkg::rx_status_t'({pid, flags});
  endfunction

  function automatic usb_rx_pkg::token_fields_t tok_ep(input logic [6:0] addr,
                                                      input logic [3:0] endp);
    usb_rx_pkg::token_fields_t t;
    t.fields.addr = addr;
    t.fields.endp = endp;
    return t;
  endfunction

  function automatic usb_rx_pkg::token_fields_t tok_frame(input logic [10:0] frame);
    usb_rx_pkg::token_fields_t t;
    t.frame = frame;
    return t;
  endfunction

  task automatic add_row(input usb_rx_pkg::pid_e pid, input int nbytes,
                         input usb_rx_pkg::token_fields_t tok, input int corrupt,
                         input logic [5:0] flags, input int exp_count);
    table_q[n_rows].pid        = pid;
    table_q[n_rows].nbytes     = nbytes;
    table_q[n_rows].tok        = tok;
    table_q[n_rows].corrupt    = corrupt;
    table_q[n_rows].exp_status = make_status(pid, flags);
    table_q[n_rows].exp_count  = exp_count;
    n_rows++;
  endtask

  task automatic check_status(input string name, input usb_rx_pkg::rx_status_t got,
                              input usb_rx_pkg::rx_status_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_token(input string name, input usb_rx_pkg::token_fields_t got,
                             input usb_rx_pkg::token_fields_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got.frame, exp.frame);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // builds sync, PID and payload with CRC, applies the corruption and sends it
  task automatic send_row(input row_t r);
    logic        bits[$];
    logic        pay[$];
    logic [7:0]  pid_byte;
    logic [7:0]  b;
    logic [4:0]  c5;
    logic [15:0] c16;
    pid_byte = {~r.pid, r.pid};
    if (r.corrupt == CORR_PID) begin
      pid_byte[7] = ~pid_byte[7];
    end
    for (int i = 0; i < 7; i++) begin
      bits.push_back(1'b0);
    end
    bits.push_back(1'b1);
    for (int i = 0; i < 8; i++) begin
      bits.push_back(pid_byte[i]);
    end
    if (r.pid[1:0] == usb_rx_pkg::PID_TYPE_TOKEN) begin
      for (int i = 0; i < 11; i++) begin
        pay.push_back(r.tok.frame[i]);
      end
      c5 = crc5_ref(r.tok.frame);
      for (int i = 4; i >= 0; i--) begin
        pay.push_back(c5[i]);
      end
    end else if (r.pid[1:0] == usb_rx_pkg::PID_TYPE_DATA) begin
      for (int n = 0; n < r.nbytes; n++) begin
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
        for (int i = 0; i < 8; i++) begin
          pay.push_back(b[i]);
        end
      end
      c16 = crc16_ref(pay);
      for (int i = 15; i >= 0; i--) begin
        pay.push_back(c16[i]);
      end
    end
    if (r.corrupt == CORR_CRC) begin
      pay[pay.size() - 1] = ~pay[pay.size() - 1];
    end
    if (r.corrupt == CORR_STUFF) begin
      repeat (7) pay.push_back(1'b1);
    end
    // the receiver gives bytes LSB first, the two CRC bytes included
    if (r.pid[1:0] == usb_rx_pkg::PID_TYPE_DATA) begin
      for (int k = 0; k + 8 <= pay.size(); k += 8) begin
        for (int i = 0; i < 8; i++) begin
          b[i] = pay[k + i];
        end
        exp_bytes.push_back(b);
      end
    end
    foreach (pay[i]) begin
      bits.push_back(pay[i]);
    end
    send_line(bits, r.corrupt != CORR_STUFF);
  endtask

  ////////////////////
  // monitor
  ////////////////////

  // outputs come from registers only, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (pkt_start) begin
        starts_seen++;
        bytes_got = 0;
      end
      if (data_put) begin
        bytes_got++;
        if (exp_bytes.size() == 0) begin
          errors++;
          $display("unexpected data byte %h at %0t in row %0d", data, $time, cur_row);
        end else begin
          check_byte("rx_data_o", data, exp_bytes.pop_front());
        end
      end
      if (pkt_end) begin
        check_status("status_o", status, table_q[cur_row].exp_status);
        check_token("token_o", token, table_q[cur_row].tok);
        checks++;
        if (bytes_got != table_q[cur_row].exp_count) begin
          errors++;
          $display("[FAIL] %0t rx_data_put_o count got %0d expected %0d", $time, bytes_got,
                   table_q[cur_row].exp_count);
        end
        // each packet opens with exactly one start pulse
        checks++;
        if (starts_seen != ends_seen + 1) begin
          errors++;
          $display("[FAIL] %0t pkt_start_o count got %0d expected %0d", $time, starts_seen,
                   ends_seen + 1);
        end
        bytes_got = 0;
        exp_bytes.delete();
        ends_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d packets ended", cycles, ends_seen);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    usb_dp = 1'b1;
    usb_dn = 1'b0;
    add_row(usb_rx_pkg::PID_OUT, 0, tok_ep(7'h05, 4'h1), CORR_NONE, 6'b110000, 0);
    add_row(usb_rx_pkg::PID_IN, 0, tok_ep(7'h7f, 4'hf), CORR_NONE, 6'b110000, 0);
    add_row(usb_rx_pkg::PID_SETUP, 0, tok_ep(7'h12, 4'h0), CORR_NONE, 6'b110000, 0);
    add_row(usb_rx_pkg::PID_SOF, 0, tok_frame(11'h5a3), CORR_NONE, 6'b110000, 0);
    add_row(usb_rx_pkg::PID_DATA0, 4, tok_frame(11'h0), CORR_NONE, 6'b110000, 6);
    add_row(usb_rx_pkg::PID_DATA1, 8, tok_frame(11'h0), CORR_NONE, 6'b110000, 10);
    add_row(usb_rx_pkg::PID_ACK, 0, tok_frame(11'h0), CORR_NONE, 6'b110000, 0);
    add_row(usb_rx_pkg::PID_OUT, 0, tok_ep(7'h33, 4'h2), CORR_CRC, 6'b101000, 0);
    add_row(usb_rx_pkg::PID_DATA0, 3, tok_frame(11'h0), CORR_CRC, 6'b100100, 5);
    add_row(usb_rx_pkg::PID_NAK, 0, tok_frame(11'h0), CORR_PID, 6'b000010, 0);
    add_row(usb_rx_pkg::PID_ACK, 0, tok_frame(11'h0), CORR_STUFF, 6'b100001, 0);
    add_row(usb_rx_pkg::PID_DATA1, 2, tok_frame(11'h0), CORR_NONE, 6'b110000, 4);
    add_row(usb_rx_pkg::PID_DATA0, 0, tok_frame(11'h0), CORR_NONE, 6'b110000, 2);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (8) @(negedge clk);

    // nothing pulses and every status field is zero out of reset
    check_status("status_o", status, usb_rx_pkg::rx_status_t'(0));
    checks++;
    if (pkt_start || pkt_end || data_put) begin
      errors++;
      $display("a packet strobe is high after reset at %0t", $time);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_row = r;
      send_row(table_q[r]);
      while (ends_seen <= r) begin
        @(negedge clk);
      end
      repeat (8) @(negedge clk);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
